/* all.f */
+incdir+include
logic/vicii_pkg.sv
logic/reset_sequencer.sv
logic/raster_counter.sv
logic/sync_gen.sv
logic/reg_port.sv
logic/border_unit.sv
logic/vicii_timing_top.sv
testbench/timing_checker.sv
testbench/tb_vicii_timing.sv

/* include/vicii_defines.svh */
`ifndef VICII_DEFINES_SVH
`define VICII_DEFINES_SVH

// frame geometry, pal
`define PAL_CYCLES 63
`define PAL_LINES 312

// frame geometry, ntsc
`define NTSC_CYCLES 65
`define NTSC_LINES 263

// 8 dots per cycle at 4x dot clock
`define PHASES_PER_CYCLE 32

// hsync cycles, inclusive
`define HSYNC_FIRST 58
`define HSYNC_LAST 62

// vsync lines, inclusive
`define VSYNC_FIRST 0
`define VSYNC_LAST 2

// top lines are always blanked
`define BLANK_LINES 8

// display window rows and columns
`define WIN_FIRST_LINE 51
`define WIN_LAST_LINE 250
`define WIN_FIRST_CYCLE 16
`define WIN_LAST_CYCLE 55

// reset hold lasts 2**RST_HOLD_BITS cycles
`define RST_HOLD_BITS 4

`endif

/* logic/border_unit.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module border_unit
   import vicii_pkg::*;
(
   input  logic        clk_dot4x,
   input  logic        internal_rst,
   input  logic        rst,
   input  video_t      vid,
   input  reg_word_u   raster_cmp,
   input  reg_word_u   border_color,
   output raster_pos_t pos,
   output logic        hsync,
   output logic        vsync,
   output logic        blank,
   output logic        border,
   output logic [3:0]  color,
   output logic        irq
);

   logic rst_q;
   logic clear;
   logic border_c;
   logic irq_c;

   // vid lags rst by one stage, so hold the outputs one extra clock
   always_ff @(posedge clk_dot4x) begin
      if (internal_rst) begin
         rst_q <= 1'b1;
      end else begin
         rst_q <= rst;
      end
   end

   assign clear = internal_rst || rst || rst_q;

   // outside the display window on any side
   assign border_c = (vid.pos.line < 9'(`WIN_FIRST_LINE)) ||
                     (vid.pos.line > 9'(`WIN_LAST_LINE)) ||
                     (vid.pos.cycle < 7'(`WIN_FIRST_CYCLE)) ||
                     (vid.pos.cycle > 7'(`WIN_LAST_CYCLE));

   // raster compare hit at the very first phase of the line
   assign irq_c = raster_cmp.raster_cmp.en &&
                  (vid.pos.line == raster_cmp.raster_cmp.line) &&
                  (vid.pos.cycle == 7'd0) && (vid.pos.phase == 5'd0);

   always_ff @(posedge clk_dot4x) begin
      pos <= vid.pos;
      if (clear) begin
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         blank  <= 1'b0;
         border <= 1'b0;
         color  <= 4'd0;
         irq    <= 1'b0;
      end else begin
         hsync  <= vid.hsync;
         vsync  <= vid.vsync;
         blank  <= vid.blank;
         border <= border_c;
         // window shows color 0, blanking forces black
         color  <= (border_c && !vid.blank) ? border_color.color.color : 4'd0;
         irq    <= irq_c;
      end
   end

   // one pulse per compare line, never a level
   irq_is_pulse: assert property (@(posedge clk_dot4x) disable iff (internal_rst)
      irq |=> !irq)
      else $error("border_unit: irq held two clocks");

endmodule

/* logic/raster_counter.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module raster_counter
   import vicii_pkg::*;
(
   input  logic        clk_dot4x,
   input  logic        internal_rst,
   input  logic        rst,
   input  chip_std_t   std,
   output raster_pos_t pos
);

   logic [6:0] cyc_limit;
   logic [8:0] line_limit;
   logic       last_phase;
   logic       last_cycle;
   logic       last_line;

   // wrap points depend on the latched standard
   always_comb begin
      if (std == NTSC) begin
         cyc_limit  = 7'(`NTSC_CYCLES);
         line_limit = 9'(`NTSC_LINES);
      end else begin
         cyc_limit  = 7'(`PAL_CYCLES);
         line_limit = 9'(`PAL_LINES);
      end
   end

   assign last_phase = (pos.phase == 5'(`PHASES_PER_CYCLE - 1));
   assign last_cycle = (pos.cycle == cyc_limit - 7'd1);
   assign last_line  = (pos.line == line_limit - 9'd1);

   always_ff @(posedge clk_dot4x) begin
      // standard tag rides along with the count
      pos.std <= std;
      if (internal_rst || rst) begin
         pos.phase <= '0;
         pos.cycle <= '0;
         pos.line  <= '0;
      end else begin
         // phase steps every clock
         pos.phase <= last_phase ? 5'd0 : pos.phase + 5'd1;
         if (last_phase) begin
            if (last_cycle) begin
               pos.cycle <= '0;
               // end of line, move down or wrap to top of frame
               pos.line  <= last_line ? 9'd0 : pos.line + 9'd1;
            end else begin
               pos.cycle <= pos.cycle + 7'd1;
            end
         end
      end
   end

   cycle_in_range: assert property (@(posedge clk_dot4x) disable iff (internal_rst)
      pos.cycle < cyc_limit)
      else $error("raster_counter: cycle %0d out of range", pos.cycle);

   line_in_range: assert property (@(posedge clk_dot4x) disable iff (internal_rst)
      pos.line < line_limit)
      else $error("raster_counter: line %0d out of range", pos.line);

endmodule

/* logic/reg_port.sv */
`timescale 1ns/10ps

module reg_port
   import vicii_pkg::*;
(
   input  logic      clk_dot4x,
   input  logic      internal_rst,
   input  logic      reg_req,
   input  reg_wr_t   reg_wr,
   output logic      reg_ack,
   output reg_word_u raster_cmp,
   output reg_word_u border_color
);

   logic take_req;

   // new request only when the previous one has fully closed
   assign take_req = reg_req && !reg_ack;

   // four-phase slave
   // ack goes up with the write and drops once req is gone
   always_ff @(posedge clk_dot4x) begin
      if (internal_rst) begin
         reg_ack <= 1'b0;
      end else if (take_req) begin
         reg_ack <= 1'b1;
      end else if (!reg_req) begin
         reg_ack <= 1'b0;
      end
   end

   // address picks how the data word is read
   // reserved fields stay zero
   always_ff @(posedge clk_dot4x) begin
      if (internal_rst) begin
         raster_cmp   <= '0;
         border_color <= '0;
      end else if (take_req) begin
         if (reg_wr.addr == 1'b0) begin
            // raster compare takes enable and line
            raster_cmp.raster_cmp.en   <= reg_wr.data.raster_cmp.en;
            raster_cmp.raster_cmp.line <= reg_wr.data.raster_cmp.line;
         end else begin
            // border color keeps only the low nibble
            border_color.color.color <= reg_wr.data.color.color;
         end
      end
   end

   // handshake rule seen from the host side
   ack_needs_req: assert property (@(posedge clk_dot4x) disable iff (internal_rst)
      $rose(reg_ack) |-> $past(reg_req))
      else $error("reg_port: ack rose without a request");

endmodule

/* logic/reset_sequencer.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module reset_sequencer
   import vicii_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       internal_rst,
   input  logic [1:0] chip,
   input  logic       locked_pal,
   input  logic       locked_ntsc,
   output logic       rst,
   output chip_std_t  std
);

   // hold counter stops once its top bit sets
   logic [`RST_HOLD_BITS:0] hold_cnt;
   logic                    running;
   logic                    sync_ff;

   // both clocks locked and hold time elapsed
   assign running = locked_pal && locked_ntsc && hold_cnt[`RST_HOLD_BITS];

   always_ff @(posedge clk_dot4x) begin
      if (internal_rst) begin
         hold_cnt <= '0;
      end else if (!hold_cnt[`RST_HOLD_BITS]) begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

   // two flops between running and rst
   // a lost lock brings rst back two edges later
   always_ff @(posedge clk_dot4x) begin
      if (internal_rst) begin
         sync_ff <= 1'b1;
         rst     <= 1'b1;
      end else begin
         sync_ff <= !running;
         rst     <= sync_ff;
      end
   end

   // standard only tracks the pins while held in reset
   // only chip[0] matters to the timing core
   always_ff @(posedge clk_dot4x) begin
      if (internal_rst || rst) begin
         std <= chip_std_t'(chip[0]);
      end
   end

   // a running raster must never see the standard move
   std_locked_in_run: assert property (@(posedge clk_dot4x)
      !internal_rst && !rst |=> $stable(std))
      else $error("reset_sequencer: std changed while out of reset");

endmodule

/* logic/sync_gen.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module sync_gen
   import vicii_pkg::*;
(
   input  logic        clk_dot4x,
   input  logic        internal_rst,
   input  logic        rst,
   input  raster_pos_t pos,
   output video_t      vid
);

   logic hsync_c;
   logic vsync_c;
   logic blank_c;

   // horizontal sync window in cycles
   assign hsync_c = (pos.cycle >= 7'(`HSYNC_FIRST)) &&
                    (pos.cycle <= 7'(`HSYNC_LAST));

   // vertical sync window in lines
   assign vsync_c = (pos.line >= 9'(`VSYNC_FIRST)) &&
                    (pos.line <= 9'(`VSYNC_LAST));

   // blank during hsync and across the top lines
   assign blank_c = hsync_c || (pos.line < 9'(`BLANK_LINES));

   always_ff @(posedge clk_dot4x) begin
      // position is carried one stage further
      vid.pos <= pos;
      if (internal_rst || rst) begin
         vid.hsync <= 1'b0;
         vid.vsync <= 1'b0;
         vid.blank <= 1'b0;
      end else begin
         vid.hsync <= hsync_c;
         vid.vsync <= vsync_c;
         vid.blank <= blank_c;
      end
   end

endmodule

/* logic/vicii_pkg.sv */
package vicii_pkg;

   // video standard, follows chip[0]
   typedef enum logic {
      PAL  = 1'b0,
      NTSC = 1'b1
   } chip_std_t;

   // raster position, common to every stage
   typedef struct packed {
      chip_std_t  std;
      logic [4:0] phase;
      logic [6:0] cycle;
      logic [8:0] line;
   } raster_pos_t;

   // stage 2 result handed to stage 3
   typedef struct packed {
      raster_pos_t pos;
      logic        hsync;
      logic        vsync;
      logic        blank;
   } video_t;

   // raster compare view of a register word
   typedef struct packed {
      logic       en;
      logic [5:0] rsvd;
      logic [8:0] line;
   } raster_cmp_t;

   // color view of a register word
   typedef struct packed {
      logic [11:0] rsvd;
      logic [3:0]  color;
   } color_reg_t;

   // same 16 bits, meaning picked by the register address
   typedef union packed {
      raster_cmp_t raster_cmp;
      color_reg_t  color;
   } reg_word_u;

   // host write: addr 0 = raster compare, addr 1 = border color
   typedef struct packed {
      logic      addr;
      reg_word_u data;
   } reg_wr_t;

endpackage

/* logic/vicii_timing_top.sv */
`timescale 1ns/10ps

module vicii_timing_top
   import vicii_pkg::*;
(
   input  logic        clk_dot4x,
   input  logic        internal_rst,
   input  logic [1:0]  chip,
   input  logic        locked_pal,
   input  logic        locked_ntsc,
   input  logic        reg_req,
   input  reg_wr_t     reg_wr,
   output logic        rst,
   output logic        reg_ack,
   output raster_pos_t pos,
   output logic        hsync,
   output logic        vsync,
   output logic        blank,
   output logic        border,
   output logic [3:0]  color,
   output logic        irq
);

   chip_std_t   std;
   raster_pos_t cnt_pos;
   video_t      vid;
   reg_word_u   raster_cmp;
   reg_word_u   border_color;

   // lock qualified reset and standard latch
   reset_sequencer u_reset_sequencer (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .chip         (chip),
      .locked_pal   (locked_pal),
      .locked_ntsc  (locked_ntsc),
      .rst          (rst),
      .std          (std)
   );

   // host register writes
   reg_port u_reg_port (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .reg_req      (reg_req),
      .reg_wr       (reg_wr),
      .reg_ack      (reg_ack),
      .raster_cmp   (raster_cmp),
      .border_color (border_color)
   );

   // stage 1
   raster_counter u_raster_counter (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .rst          (rst),
      .std          (std),
      .pos          (cnt_pos)
   );

   // stage 2
   sync_gen u_sync_gen (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .rst          (rst),
      .pos          (cnt_pos),
      .vid          (vid)
   );

   // stage 3, drives every video output
   border_unit u_border_unit (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .rst          (rst),
      .vid          (vid),
      .raster_cmp   (raster_cmp),
      .border_color (border_color),
      .pos          (pos),
      .hsync        (hsync),
      .vsync        (vsync),
      .blank        (blank),
      .border       (border),
      .color        (color),
      .irq          (irq)
   );

endmodule

/* testbench/tb_vicii_timing.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module tb_vicii_timing
   import vicii_pkg::*;
();

   localparam int NUM_ROWS  = 8;
   localparam int ACK_LIMIT = 16;
   localparam int CLK_NS    = 100;

   // one step of the run
   typedef struct packed {
      logic [1:0] chip;
      logic [1:0] locks;
      logic       wr_valid;
      reg_wr_t    wr;
      logic [7:0] lines;
   } row_t;

   logic        clk_dot4x;
   logic        internal_rst;
   logic [1:0]  chip;
   logic        locked_pal;
   logic        locked_ntsc;
   logic        reg_req;
   reg_wr_t     reg_wr;
   logic        rst;
   logic        reg_ack;
   raster_pos_t pos;
   logic        hsync;
   logic        vsync;
   logic        blank;
   logic        border;
   logic [3:0]  color;
   logic        irq;
   int          error_count;
   int          check_count;
   int          drv_errors = 0;
   int          total_lines;
   int          seed_draw;
   row_t        rows [NUM_ROWS];

   always #(CLK_NS / 2) clk_dot4x = ~clk_dot4x;

   vicii_timing_top DUT (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .chip         (chip),
      .locked_pal   (locked_pal),
      .locked_ntsc  (locked_ntsc),
      .reg_req      (reg_req),
      .reg_wr       (reg_wr),
      .rst          (rst),
      .reg_ack      (reg_ack),
      .pos          (pos),
      .hsync        (hsync),
      .vsync        (vsync),
      .blank        (blank),
      .border       (border),
      .color        (color),
      .irq          (irq)
   );

   timing_checker watch (
      .clk_dot4x    (clk_dot4x),
      .internal_rst (internal_rst),
      .chip         (chip),
      .locked_pal   (locked_pal),
      .locked_ntsc  (locked_ntsc),
      .reg_req      (reg_req),
      .reg_wr       (reg_wr),
      .rst          (rst),
      .reg_ack      (reg_ack),
      .pos          (pos),
      .hsync        (hsync),
      .vsync        (vsync),
      .blank        (blank),
      .border       (border),
      .color        (color),
      .irq          (irq),
      .error_count  (error_count),
      .check_count  (check_count)
   );

   function automatic reg_wr_t make_cmp_write(input logic en, input logic [8:0] line);
      reg_wr_t w;
      w                      = '0;
      w.addr                 = 1'b0;
      w.data.raster_cmp.en   = en;
      w.data.raster_cmp.line = line;
      return w;
   endfunction

   function automatic reg_wr_t make_color_write(input logic [3:0] c);
      reg_wr_t w;
      w                  = '0;
      w.addr             = 1'b1;
      w.data.color.color = c;
      return w;
   endfunction

   // four-phase host side
   // ack is registered on the first edge that sees req and shows at the second
   task automatic write_reg(input reg_wr_t w);
      int waits;
      @(posedge clk_dot4x);
      reg_wr  <= w;
      reg_req <= 1'b1;
      waits = 0;
      do begin
         @(posedge clk_dot4x);
         waits++;
      end while (reg_ack !== 1'b1 && waits < ACK_LIMIT);
      if (reg_ack !== 1'b1) begin
         drv_errors++;
         $display("register write at %0t was never acknowledged", $time);
      end else if (waits != 2) begin
         drv_errors++;
         $display("FAILED %0t: reg_ack after %0d clocks, expected 2", $time, waits);
      end
      reg_req <= 1'b0;
      waits = 0;
      do begin
         @(posedge clk_dot4x);
         waits++;
      end while (reg_ack !== 1'b0 && waits < ACK_LIMIT);
      if (reg_ack !== 1'b0) begin
         drv_errors++;
         $display("reg_ack at %0t stayed high after the request was dropped", $time);
      end
   endtask

   task automatic wait_for_run();
      while (rst !== 1'b0) begin
         @(posedge clk_dot4x);
      end
   endtask

   task automatic run_lines(input int lines, input logic ntsc);
      int cycles;
      cycles = ntsc ? `NTSC_CYCLES : `PAL_CYCLES;
      repeat (lines * cycles * `PHASES_PER_CYCLE) @(posedge clk_dot4x);
   endtask

   task automatic watchdog(input realtime limit);
      #(limit);
      $display("watchdog: simulation ran past %0t without finishing", $time);
      $display("SOME TESTS FAILED");
      $finish;
   endtask

   initial begin
      clk_dot4x    = 1'b0;
      internal_rst = 1'b1;
      chip         = 2'b00;
      locked_pal   = 1'b1;
      locked_ntsc  = 1'b1;
      reg_req      = 1'b0;
      reg_wr       = '0;
      // seed the generator once
      seed_draw    = $urandom(19);
      // locks are {locked_pal, locked_ntsc}
      rows[0] = '{chip: 2'b00, locks: 2'b11, wr_valid: 1'b1,
                  wr: make_color_write(4'hE), lines: 8'd60};
      // random compare line a few lines ahead of the raster
      rows[1] = '{chip: 2'b00, locks: 2'b11, wr_valid: 1'b1,
                  wr: make_cmp_write(1'b1, 9'(62 + $urandom % 6)), lines: 8'd12};
      // first draw picks the new border color
      rows[2] = '{chip: 2'b00, locks: 2'b11, wr_valid: 1'b1,
                  wr: make_color_write(4'(1 + seed_draw % 15)), lines: 8'd4};
      // pal lock lost while the pins switch to ntsc
      rows[3] = '{chip: 2'b01, locks: 2'b01, wr_valid: 1'b0, wr: '0, lines: 8'd1};
      rows[4] = '{chip: 2'b01, locks: 2'b11, wr_valid: 1'b1,
                  wr: make_cmp_write(1'b1, 9'd5), lines: 8'd8};
      // compare disabled on a line still ahead
      rows[5] = '{chip: 2'b01, locks: 2'b11, wr_valid: 1'b1,
                  wr: make_cmp_write(1'b0, 9'd10), lines: 8'd6};
      rows[6] = '{chip: 2'b00, locks: 2'b10, wr_valid: 1'b0, wr: '0, lines: 8'd1};
      rows[7] = '{chip: 2'b00, locks: 2'b11, wr_valid: 1'b0, wr: '0, lines: 8'd3};
      total_lines = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         total_lines += rows[i].lines;
      end
      // every row at the longest line plus slack for resets and writes
      fork
         watchdog(real'(total_lines + 10) * `NTSC_CYCLES * `PHASES_PER_CYCLE * CLK_NS);
      join_none
      repeat (2) @(posedge clk_dot4x);
      internal_rst <= 1'b0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         @(posedge clk_dot4x);
         chip        <= rows[i].chip;
         locked_pal  <= rows[i].locks[1];
         locked_ntsc <= rows[i].locks[0];
         if (rows[i].locks == 2'b11) begin
            wait_for_run();
         end
         if (rows[i].wr_valid) begin
            write_reg(rows[i].wr);
         end
         run_lines(rows[i].lines, rows[i].chip[0]);
      end
      // drain the last outputs through the pipeline
      repeat (4) @(posedge clk_dot4x);
      $display("checks: %0d, checker errors: %0d, driver errors: %0d",
               check_count, error_count, drv_errors);
      if (error_count == 0 && drv_errors == 0 && check_count > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* testbench/timing_checker.sv */
`timescale 1ns/10ps

`include "vicii_defines.svh"

module timing_checker
   import vicii_pkg::*;
(
   input  logic        clk_dot4x,
   input  logic        internal_rst,
   input  logic [1:0]  chip,
   input  logic        locked_pal,
   input  logic        locked_ntsc,
   input  logic        reg_req,
   input  reg_wr_t     reg_wr,
   input  logic        rst,
   input  logic        reg_ack,
   input  raster_pos_t pos,
   input  logic        hsync,
   input  logic        vsync,
   input  logic        blank,
   input  logic        border,
   input  logic [3:0]  color,
   input  logic        irq,
   output int          error_count,
   output int          check_count
);

   localparam int HOLD_CYCLES = 1 << `RST_HOLD_BITS;

   int          errors = 0;
   int          checks = 0;
   int          edges = 0;
   // reset release model
   int          hold_m = 0;
   logic        sync_m = 1'b1;
   logic        rst_m = 1'b1;
   // reset seen one and two edges back, clears the outputs
   logic        held_d1 = 1'b1;
   logic        held_d2 = 1'b1;
   chip_std_t   std_m = PAL;
   // stage 1 count, then the two pipeline delays
   raster_pos_t cnt_m = '0;
   raster_pos_t mid_m = '0;
   raster_pos_t out_m = '0;
   // register port model, prev copies line up with stage 3
   logic        ack_m = 1'b0;
   reg_word_u   cmp_m = '0;
   reg_word_u   cmp_prev = '0;
   reg_word_u   bc_m = '0;
   reg_word_u   bc_prev = '0;

   assign error_count = errors;
   assign check_count = checks;

   function automatic logic in_range(input int v, input int lo, input int hi);
      return (v >= lo) && (v <= hi);
   endfunction

   // step one dot phase through the whole frame as a flat index
   function automatic raster_pos_t step_pos(input raster_pos_t p, input chip_std_t s);
      raster_pos_t n;
      int          cycles;
      int          lines;
      int          idx;
      cycles  = (s == NTSC) ? `NTSC_CYCLES : `PAL_CYCLES;
      lines   = (s == NTSC) ? `NTSC_LINES : `PAL_LINES;
      idx     = (int'(p.line) * cycles + int'(p.cycle)) * `PHASES_PER_CYCLE;
      idx     = (idx + int'(p.phase) + 1) % (lines * cycles * `PHASES_PER_CYCLE);
      n.std   = s;
      n.phase = 5'(idx % `PHASES_PER_CYCLE);
      n.cycle = 7'((idx / `PHASES_PER_CYCLE) % cycles);
      n.line  = 9'(idx / (`PHASES_PER_CYCLE * cycles));
      return n;
   endfunction

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // inputs and outputs are sampled before this edge updates them
   always @(posedge clk_dot4x) begin : watch_edge
      logic       held;
      logic       take;
      logic       clr;
      logic       hs_e;
      logic       vs_e;
      logic       bl_e;
      logic       bd_e;
      logic [3:0] col_e;
      logic       irq_e;
      held  = internal_rst || rst_m;
      take  = reg_req && !ack_m;
      clr   = held_d1 || held_d2;
      hs_e  = in_range(pos.cycle, `HSYNC_FIRST, `HSYNC_LAST);
      vs_e  = in_range(pos.line, `VSYNC_FIRST, `VSYNC_LAST);
      bl_e  = hs_e || (pos.line < `BLANK_LINES);
      bd_e  = !(in_range(pos.line, `WIN_FIRST_LINE, `WIN_LAST_LINE) &&
                in_range(pos.cycle, `WIN_FIRST_CYCLE, `WIN_LAST_CYCLE));
      col_e = (bd_e && !bl_e) ? bc_prev.color.color : 4'd0;
      irq_e = cmp_prev.raster_cmp.en && (pos.line == cmp_prev.raster_cmp.line) &&
              (pos.cycle == 7'd0) && (pos.phase == 5'd0);
      // skip the first edges while the pipeline still holds x
      if (edges > 4) begin
         compare_value("rst", rst, rst_m);
         compare_value("reg_ack", reg_ack, ack_m);
         compare_value("pos", pos, out_m);
         compare_value("hsync", hsync, !clr && hs_e);
         compare_value("vsync", vsync, !clr && vs_e);
         compare_value("blank", blank, !clr && bl_e);
         compare_value("border", border, !clr && bd_e);
         compare_value("color", color, clr ? 4'd0 : col_e);
         compare_value("irq", irq, !clr && irq_e);
      end
      edges++;
      held_d2 = held_d1;
      held_d1 = held;
      // position pipeline, count is zero and tagged with std during reset
      out_m = mid_m;
      mid_m = cnt_m;
      if (held) begin
         cnt_m     = '0;
         cnt_m.std = std_m;
         std_m     = chip_std_t'(chip[0]);
      end else begin
         cnt_m = step_pos(cnt_m, std_m);
      end
      // rst follows running with two edges of delay
      if (internal_rst) begin
         hold_m = 0;
         sync_m = 1'b1;
         rst_m  = 1'b1;
      end else begin
         rst_m  = sync_m;
         sync_m = !(locked_pal && locked_ntsc && hold_m >= HOLD_CYCLES);
         if (hold_m < HOLD_CYCLES) begin
            hold_m++;
         end
      end
      cmp_prev = cmp_m;
      bc_prev  = bc_m;
      if (internal_rst) begin
         ack_m = 1'b0;
         cmp_m = '0;
         bc_m  = '0;
      end else begin
         if (take && reg_wr.addr == 1'b0) begin
            cmp_m = reg_wr.data;
         end
         if (take && reg_wr.addr == 1'b1) begin
            bc_m = reg_wr.data;
         end
         ack_m = take ? 1'b1 : (reg_req ? ack_m : 1'b0);
      end
   end

endmodule
